/* source/tomasulo_settings.svh */
`ifndef TOMASULO_SETTINGS_SVH
`define TOMASULO_SETTINGS_SVH

// Reorder buffer entries as 2**TAG_WIDTH
`define ROB_DEPTH 8

// Bits in a reorder entry number
`define TAG_WIDTH 3

// ALU reservation stations
`define RS_COUNT 3

`endif

/* source/lc3b_isa_pkg.sv */
package lc3b_isa_pkg;

	typedef logic [15:0] lc3b_word;
	typedef logic [2:0] lc3b_reg;

	// LC-3b opcode encodings; values outside this set issue as no-ops
	typedef enum logic [3:0]
	{
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_jmp = 4'b1100,
		op_shf = 4'b1101,
		op_lea = 4'b1110
	} lc3b_opcode;

	// Register or immediate ALU form
	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_reg dest;
		lc3b_reg sr1;
		logic imm_flag;    // Set for imm5
		logic [4:0] src2;  // imm5, or sr2 in the low three bits
	} lc3b_alu_form;

	// PC-relative form used by BR and LEA
	typedef struct packed
	{
		lc3b_opcode opcode;
		lc3b_reg dest;     // nzp for BR
		logic [8:0] offset9;
	} lc3b_offset_form;

	typedef union packed
	{
		lc3b_alu_form alu;
		lc3b_offset_form offs;
	} lc3b_instr;

endpackage

/* source/tomasulo_pkg.sv */
`include "tomasulo_settings.svh"

package tomasulo_pkg;

	typedef logic [`TAG_WIDTH-1:0] rob_addr_t;

	typedef struct packed
	{
		lc3b_isa_pkg::lc3b_instr instr;
		lc3b_isa_pkg::lc3b_word pc;   // Already incremented past the instruction
		logic predict_taken;
	} fetch_t;

	// One architectural register as seen by issue
	typedef struct packed
	{
		logic busy;
		rob_addr_t owner;
		lc3b_isa_pkg::lc3b_word data;
	} reg_status_t;

	typedef struct packed
	{
		logic ready;
		lc3b_isa_pkg::lc3b_word value;
	} rob_lookup_t;

	typedef struct packed
	{
		logic valid;
		rob_addr_t tag;
		lc3b_isa_pkg::lc3b_word data;
	} cdb_t;

	typedef struct packed
	{
		logic valid;
		lc3b_isa_pkg::lc3b_opcode opcode;
		lc3b_isa_pkg::lc3b_word vj;
		lc3b_isa_pkg::lc3b_word vk;
		rob_addr_t qj;
		rob_addr_t qk;
		logic j_pending;   // vj still waits on qj
		logic k_pending;
		rob_addr_t dest;
	} rs_entry_t;

	typedef struct packed
	{
		logic valid;
		lc3b_isa_pkg::lc3b_opcode opcode;
		logic has_dest;
		lc3b_isa_pkg::lc3b_reg dest;
		logic value_ready;
		lc3b_isa_pkg::lc3b_word value;
	} rob_alloc_t;

	typedef struct packed
	{
		logic valid;
		lc3b_isa_pkg::lc3b_reg dest;
	} reg_claim_t;

	typedef struct packed
	{
		logic valid;
		lc3b_isa_pkg::lc3b_opcode opcode;
		logic has_dest;
		lc3b_isa_pkg::lc3b_reg dest;
		lc3b_isa_pkg::lc3b_word value;
		rob_addr_t entry;
	} retire_t;

endpackage

/* source/issue_control.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module issue_control
(
	input logic clk,
	input logic rst_n,
	input logic fetch_req,
	input tomasulo_pkg::fetch_t fetch,
	input logic [`RS_COUNT-1:0] station_busy,
	input logic rob_full,
	input tomasulo_pkg::rob_addr_t rob_tail,
	input tomasulo_pkg::reg_status_t sr1_status,
	input tomasulo_pkg::reg_status_t sr2_status,
	input tomasulo_pkg::rob_lookup_t sr1_lookup,
	input tomasulo_pkg::rob_lookup_t sr2_lookup,
	input tomasulo_pkg::cdb_t cdb,
	output logic fetch_ack,
	output lc3b_isa_pkg::lc3b_reg sr1_sel,
	output lc3b_isa_pkg::lc3b_reg sr2_sel,
	output tomasulo_pkg::rs_entry_t station_write,
	output logic [$clog2(`RS_COUNT)-1:0] station_index,
	output tomasulo_pkg::rob_alloc_t rob_alloc,
	output tomasulo_pkg::reg_claim_t reg_claim
);

	localparam int IDX_W = $clog2(`RS_COUNT);

	lc3b_isa_pkg::lc3b_instr instr;
	lc3b_isa_pkg::lc3b_opcode opcode;
	lc3b_isa_pkg::lc3b_word imm5_sext;
	lc3b_isa_pkg::lc3b_word adj9;
	logic is_alu;
	logic use_imm;
	logic stall;
	logic issued;
	logic do_issue;
	lc3b_isa_pkg::lc3b_word j_val;
	lc3b_isa_pkg::lc3b_word k_val;
	tomasulo_pkg::rob_addr_t j_tag;
	tomasulo_pkg::rob_addr_t k_tag;
	logic j_wait;
	logic k_wait;

	// Register first, then the bus, then a finished reorder entry
	function automatic void resolve_operand
	(
		input tomasulo_pkg::reg_status_t status,
		input tomasulo_pkg::rob_lookup_t lookup,
		input tomasulo_pkg::cdb_t bus,
		output lc3b_isa_pkg::lc3b_word value,
		output tomasulo_pkg::rob_addr_t tag,
		output logic pending
	);
		value = status.data;
		tag = status.owner;
		pending = 1'b0;
		if (status.busy)
		begin
			if (bus.valid && bus.tag == status.owner)
				value = bus.data;
			else if (lookup.ready)
				value = lookup.value;
			else
				pending = 1'b1;
		end
	endfunction

	assign instr = fetch.instr;
	assign opcode = instr.alu.opcode;
	assign sr1_sel = instr.alu.sr1;
	assign sr2_sel = instr.alu.src2[2:0];
	assign imm5_sext = {{11{instr.alu.src2[4]}}, instr.alu.src2};
	assign adj9 = {{6{instr.offs.offset9[8]}}, instr.offs.offset9, 1'b0};

	assign is_alu = (opcode == lc3b_isa_pkg::op_add) || (opcode == lc3b_isa_pkg::op_and) ||
		(opcode == lc3b_isa_pkg::op_not) || (opcode == lc3b_isa_pkg::op_shf);
	// NOT ignores sr2 and SHF always takes its amount from imm5
	assign use_imm = instr.alu.imm_flag || (opcode == lc3b_isa_pkg::op_not) ||
		(opcode == lc3b_isa_pkg::op_shf);

	assign stall = rob_full || (is_alu && (&station_busy));
	assign do_issue = fetch_req && !fetch_ack && !issued && !stall;

	// Lowest numbered free station
	always_comb
	begin
		station_index = '0;
		for (int i = `RS_COUNT - 1; i >= 0; i--)
			if (!station_busy[i])
				station_index = IDX_W'(i);
	end

	always_comb
	begin
		resolve_operand(sr1_status, sr1_lookup, cdb, j_val, j_tag, j_wait);
		resolve_operand(sr2_status, sr2_lookup, cdb, k_val, k_tag, k_wait);
		station_write = '0;
		rob_alloc = '0;
		reg_claim = '0;
		if (do_issue)
		begin
			rob_alloc.valid = 1'b1;
			rob_alloc.opcode = opcode;
			rob_alloc.dest = instr.alu.dest;
			rob_alloc.value_ready = 1'b1;   // Cleared below for ALU work
			case (opcode)
				lc3b_isa_pkg::op_add, lc3b_isa_pkg::op_and,
				lc3b_isa_pkg::op_not, lc3b_isa_pkg::op_shf:
				begin
					station_write.valid = 1'b1;
					station_write.opcode = opcode;
					station_write.vj = j_val;
					station_write.qj = j_tag;
					station_write.j_pending = j_wait;
					if (use_imm)
						station_write.vk = imm5_sext;
					else
					begin
						station_write.vk = k_val;
						station_write.qk = k_tag;
						station_write.k_pending = k_wait;
					end
					station_write.dest = rob_tail;
					rob_alloc.has_dest = 1'b1;
					rob_alloc.value_ready = 1'b0;
					reg_claim.valid = 1'b1;
					reg_claim.dest = instr.alu.dest;
				end
				lc3b_isa_pkg::op_br:
				begin
					// Record the path the fetch did not take
					if (fetch.predict_taken)
						rob_alloc.value = fetch.pc;
					else
						rob_alloc.value = fetch.pc + adj9;
				end
				lc3b_isa_pkg::op_lea:
				begin
					rob_alloc.value = fetch.pc + adj9;
					rob_alloc.has_dest = 1'b1;
					reg_claim.valid = 1'b1;
					reg_claim.dest = instr.offs.dest;
				end
				default:;   // No-op entry that retires without a write
			endcase
		end
	end

	// Four-phase handshake state
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			fetch_ack <= 1'b0;
			issued <= 1'b0;
		end
		else
		begin
			if (do_issue)
				fetch_ack <= 1'b1;
			else if (!fetch_req)
				fetch_ack <= 1'b0;   // Req seen low
			if (do_issue)
				issued <= 1'b1;
			else if (!fetch_req)
				issued <= 1'b0;
		end
	end

endmodule

/* source/reg_status.sv */
`timescale 1ns/1ps

module reg_status
(
	input logic clk,
	input logic rst_n,
	input lc3b_isa_pkg::lc3b_reg sr1_sel,
	input lc3b_isa_pkg::lc3b_reg sr2_sel,
	input tomasulo_pkg::reg_claim_t reg_claim,
	input tomasulo_pkg::rob_addr_t rob_tail,
	input tomasulo_pkg::retire_t retire,
	output tomasulo_pkg::reg_status_t sr1_status,
	output tomasulo_pkg::reg_status_t sr2_status
);

	// Data, busy bit and owning reorder entry per register
	tomasulo_pkg::reg_status_t regs [8];

	assign sr1_status = regs[sr1_sel];
	assign sr2_status = regs[sr2_sel];

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 8; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (retire.valid && retire.has_dest)
			begin
				regs[retire.dest].data <= retire.value;
				// A younger writer may already own the register
				if (regs[retire.dest].owner == retire.entry)
					regs[retire.dest].busy <= 1'b0;
			end
			// New claim overrides a same-cycle retire
			if (reg_claim.valid)
			begin
				regs[reg_claim.dest].busy <= 1'b1;
				regs[reg_claim.dest].owner <= rob_tail;
			end
		end
	end

endmodule

/* source/alu_stations.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module alu_stations
(
	input logic clk,
	input logic rst_n,
	input tomasulo_pkg::rs_entry_t station_write,
	input logic [$clog2(`RS_COUNT)-1:0] station_index,
	output logic [`RS_COUNT-1:0] station_busy,
	output tomasulo_pkg::cdb_t cdb
);

	localparam int IDX_W = $clog2(`RS_COUNT);

	tomasulo_pkg::rs_entry_t stations [`RS_COUNT];
	logic [`RS_COUNT-1:0] ready;
	logic any_ready;
	logic [IDX_W-1:0] sel;
	tomasulo_pkg::rs_entry_t chosen;
	lc3b_isa_pkg::lc3b_word result;

	always_comb
	begin
		for (int i = 0; i < `RS_COUNT; i++)
		begin
			station_busy[i] = stations[i].valid;
			ready[i] = stations[i].valid && !stations[i].j_pending && !stations[i].k_pending;
		end
	end

	// Lowest numbered ready station owns the bus
	always_comb
	begin
		sel = '0;
		any_ready = 1'b0;
		for (int i = `RS_COUNT - 1; i >= 0; i--)
		begin
			if (ready[i])
			begin
				sel = IDX_W'(i);
				any_ready = 1'b1;
			end
		end
	end

	assign chosen = stations[sel];

	always_comb
	begin
		case (chosen.opcode)
			lc3b_isa_pkg::op_add: result = chosen.vj + chosen.vk;
			lc3b_isa_pkg::op_and: result = chosen.vj & chosen.vk;
			lc3b_isa_pkg::op_not: result = ~chosen.vj;
			lc3b_isa_pkg::op_shf:
			begin
				if (chosen.vk[4])
					result = chosen.vj >> chosen.vk[3:0];   // Logical only
				else
					result = chosen.vj << chosen.vk[3:0];
			end
			default: result = '0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `RS_COUNT; i++)
				stations[i].valid <= 1'b0;
			cdb.valid <= 1'b0;
		end
		else
		begin
			cdb.valid <= any_ready;
			cdb.tag <= chosen.dest;
			cdb.data <= result;
			// Waiting operands snoop the bus
			for (int i = 0; i < `RS_COUNT; i++)
			begin
				if (stations[i].j_pending && cdb.valid && cdb.tag == stations[i].qj)
				begin
					stations[i].vj <= cdb.data;
					stations[i].j_pending <= 1'b0;
				end
				if (stations[i].k_pending && cdb.valid && cdb.tag == stations[i].qk)
				begin
					stations[i].vk <= cdb.data;
					stations[i].k_pending <= 1'b0;
				end
			end
			if (any_ready)
				stations[sel].valid <= 1'b0;   // Freed as it broadcasts
			if (station_write.valid)
				stations[station_index] <= station_write;
		end
	end

endmodule

/* source/reorder_buffer.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module reorder_buffer
(
	input logic clk,
	input logic rst_n,
	input tomasulo_pkg::rob_alloc_t rob_alloc,
	input tomasulo_pkg::cdb_t cdb,
	input tomasulo_pkg::reg_status_t sr1_status,
	input tomasulo_pkg::reg_status_t sr2_status,
	output logic rob_full,
	output tomasulo_pkg::rob_addr_t rob_tail,
	output tomasulo_pkg::rob_lookup_t sr1_lookup,
	output tomasulo_pkg::rob_lookup_t sr2_lookup,
	output tomasulo_pkg::retire_t retire
);

	localparam logic [`TAG_WIDTH:0] FULL_COUNT = (`TAG_WIDTH + 1)'(`ROB_DEPTH);

	// Valid marks an occupied slot
	tomasulo_pkg::rob_alloc_t entries [`ROB_DEPTH];
	tomasulo_pkg::rob_addr_t head;
	logic [`TAG_WIDTH:0] count;
	logic do_retire;

	assign rob_full = (count == FULL_COUNT);

	// Operand lookups at each source's owning entry
	assign sr1_lookup.ready = entries[sr1_status.owner].value_ready;
	assign sr1_lookup.value = entries[sr1_status.owner].value;
	assign sr2_lookup.ready = entries[sr2_status.owner].value_ready;
	assign sr2_lookup.value = entries[sr2_status.owner].value;

	assign do_retire = entries[head].valid && entries[head].value_ready;

	always_comb
	begin
		retire.valid = do_retire;
		retire.opcode = entries[head].opcode;
		retire.has_dest = entries[head].has_dest;
		retire.dest = entries[head].dest;
		retire.value = entries[head].value;
		retire.entry = head;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `ROB_DEPTH; i++)
				entries[i].valid <= 1'b0;
			head <= '0;
			rob_tail <= '0;
			count <= '0;
		end
		else
		begin
			// Completion from the bus
			if (cdb.valid)
			begin
				entries[cdb.tag].value_ready <= 1'b1;
				entries[cdb.tag].value <= cdb.data;
			end
			if (do_retire)
			begin
				entries[head].valid <= 1'b0;
				head <= head + 1'b1;
			end
			if (rob_alloc.valid)
			begin
				entries[rob_tail] <= rob_alloc;
				rob_tail <= rob_tail + 1'b1;   // Wraps with ROB_DEPTH a power of two
			end
			case ({rob_alloc.valid, do_retire})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* source/tomasulo_core.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module tomasulo_core
(
	input logic clk,
	input logic rst_n,
	input logic fetch_req,
	input tomasulo_pkg::fetch_t fetch,
	output logic fetch_ack,
	output tomasulo_pkg::retire_t retire
);

	lc3b_isa_pkg::lc3b_reg sr1_sel;
	lc3b_isa_pkg::lc3b_reg sr2_sel;
	tomasulo_pkg::reg_status_t sr1_status;
	tomasulo_pkg::reg_status_t sr2_status;
	tomasulo_pkg::rob_lookup_t sr1_lookup;
	tomasulo_pkg::rob_lookup_t sr2_lookup;
	tomasulo_pkg::rs_entry_t station_write;
	logic [$clog2(`RS_COUNT)-1:0] station_index;
	logic [`RS_COUNT-1:0] station_busy;
	tomasulo_pkg::rob_alloc_t rob_alloc;
	tomasulo_pkg::reg_claim_t reg_claim;
	tomasulo_pkg::cdb_t cdb;
	tomasulo_pkg::rob_addr_t rob_tail;
	logic rob_full;

	// Decode and issue
	issue_control u_issue_control
	(
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch(fetch),
		.station_busy(station_busy),
		.rob_full(rob_full),
		.rob_tail(rob_tail),
		.sr1_status(sr1_status),
		.sr2_status(sr2_status),
		.sr1_lookup(sr1_lookup),
		.sr2_lookup(sr2_lookup),
		.cdb(cdb),
		.fetch_ack(fetch_ack),
		.sr1_sel(sr1_sel),
		.sr2_sel(sr2_sel),
		.station_write(station_write),
		.station_index(station_index),
		.rob_alloc(rob_alloc),
		.reg_claim(reg_claim)
	);

	reg_status u_reg_status
	(
		.clk(clk),
		.rst_n(rst_n),
		.sr1_sel(sr1_sel),
		.sr2_sel(sr2_sel),
		.reg_claim(reg_claim),
		.rob_tail(rob_tail),
		.retire(retire),
		.sr1_status(sr1_status),
		.sr2_status(sr2_status)
	);

	alu_stations u_alu_stations
	(
		.clk(clk),
		.rst_n(rst_n),
		.station_write(station_write),
		.station_index(station_index),
		.station_busy(station_busy),
		.cdb(cdb)
	);

	// In-order completion and writeback
	reorder_buffer u_reorder_buffer
	(
		.clk(clk),
		.rst_n(rst_n),
		.rob_alloc(rob_alloc),
		.cdb(cdb),
		.sr1_status(sr1_status),
		.sr2_status(sr2_status),
		.rob_full(rob_full),
		.rob_tail(rob_tail),
		.sr1_lookup(sr1_lookup),
		.sr2_lookup(sr2_lookup),
		.retire(retire)
	);

endmodule

/* tests/tomasulo_core_sva.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module tomasulo_core_sva
(
	input logic clk,
	input logic rst_n,
	input logic fetch_req,
	input logic fetch_ack,
	input tomasulo_pkg::retire_t retire
);

	logic ack_q;
	logic [7:0] in_flight;   // Acked but not yet retired

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			ack_q <= 1'b0;
			in_flight <= '0;
		end
		else
		begin
			ack_q <= fetch_ack;
			in_flight <= in_flight + 8'(fetch_ack && !ack_q) - 8'(retire.valid);
		end
	end

	// Ack only answers a raised request
	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(fetch_ack) |-> $past(fetch_req))
		else $error("fetch_ack rose while fetch_req was low");

	ack_held: assert property (@(posedge clk) disable iff (!rst_n)
		fetch_ack && fetch_req |=> fetch_ack)
		else $error("fetch_ack dropped before fetch_req fell");

	occupancy: assert property (@(posedge clk) disable iff (!rst_n)
		in_flight <= `ROB_DEPTH)
		else $error("More instructions in flight than reorder entries");

	quiet_after_reset: assert property (@(posedge clk)
		!rst_n |=> !fetch_ack && !retire.valid)
		else $error("fetch_ack or retire.valid high after reset");

endmodule

bind tomasulo_core tomasulo_core_sva u_tomasulo_core_sva
(
	.clk(clk),
	.rst_n(rst_n),
	.fetch_req(fetch_req),
	.fetch_ack(fetch_ack),
	.retire(retire)
);

/* tests/tomasulo_core_tb.sv */
`timescale 1ns/1ps
`include "tomasulo_settings.svh"

module tomasulo_core_tb;

	localparam int ACK_LIMIT = 200;
	localparam int DRAIN_LIMIT = 2000;
	localparam int RANDOM_COUNT = 400;

	logic clk;
	logic rst_n;
	logic fetch_req;
	tomasulo_pkg::fetch_t fetch;
	logic fetch_ack;
	tomasulo_pkg::retire_t retire;

	int unsigned lcg_state = 14759;
	lc3b_isa_pkg::lc3b_word ref_regs [8];   // Architectural state in program order
	lc3b_isa_pkg::lc3b_word pc;
	int unsigned alloc_count;   // Instructions sent since reset
	tomasulo_pkg::retire_t pending_retires [$];
	tomasulo_pkg::retire_t want;

	tomasulo_core u_tomasulo_core
	(
		.clk(clk),
		.rst_n(rst_n),
		.fetch_req(fetch_req),
		.fetch(fetch),
		.fetch_ack(fetch_ack),
		.retire(retire)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "Run stopped");
	endtask

	function automatic logic [15:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// Reference result of one instruction, applied to ref_regs
	function automatic tomasulo_pkg::retire_t model_step(input tomasulo_pkg::fetch_t f);
		tomasulo_pkg::retire_t r;
		lc3b_isa_pkg::lc3b_word a;
		lc3b_isa_pkg::lc3b_word b;
		lc3b_isa_pkg::lc3b_word adj;
		r = '0;
		r.valid = 1'b1;
		r.opcode = f.instr.alu.opcode;
		r.dest = f.instr.alu.dest;
		a = ref_regs[f.instr.alu.sr1];
		if (f.instr.alu.imm_flag)
			b = {{11{f.instr.alu.src2[4]}}, f.instr.alu.src2};
		else
			b = ref_regs[f.instr.alu.src2[2:0]];
		adj = {{6{f.instr.offs.offset9[8]}}, f.instr.offs.offset9, 1'b0};
		r.has_dest = 1'b1;
		case (r.opcode)
			lc3b_isa_pkg::op_add: r.value = a + b;
			lc3b_isa_pkg::op_and: r.value = a & b;
			lc3b_isa_pkg::op_not: r.value = ~a;
			lc3b_isa_pkg::op_shf:
			begin
				if (f.instr.alu.src2[4])
					r.value = a >> f.instr.alu.src2[3:0];
				else
					r.value = a << f.instr.alu.src2[3:0];
			end
			lc3b_isa_pkg::op_lea: r.value = f.pc + adj;
			lc3b_isa_pkg::op_br:
			begin
				r.has_dest = 1'b0;
				r.value = f.predict_taken ? f.pc : f.pc + adj;   // Path not taken
			end
			default: r.has_dest = 1'b0;
		endcase
		if (r.has_dest)
			ref_regs[r.dest] = r.value;
		return r;
	endfunction

	// Registers r0 to r3 only so that dependencies are dense
	function automatic lc3b_isa_pkg::lc3b_instr random_instr();
		lc3b_isa_pkg::lc3b_instr ins;
		logic [15:0] r;
		r = next_random();
		ins = next_random();
		ins.alu.dest = {1'b0, r[5:4]};
		ins.alu.sr1 = {1'b0, r[7:6]};
		if (!ins.alu.imm_flag)
			ins.alu.src2[2:0] = {1'b0, r[9:8]};
		case (r[3:0])
			4'd0, 4'd1, 4'd2: ins.alu.opcode = lc3b_isa_pkg::op_add;
			4'd3, 4'd4, 4'd5: ins.alu.opcode = lc3b_isa_pkg::op_and;
			4'd6, 4'd7: ins.alu.opcode = lc3b_isa_pkg::op_not;
			4'd8, 4'd9: ins.alu.opcode = lc3b_isa_pkg::op_shf;
			4'd10, 4'd11: ins.alu.opcode = lc3b_isa_pkg::op_lea;
			4'd12, 4'd13: ins.alu.opcode = lc3b_isa_pkg::op_br;
			4'd14: ins.alu.opcode = r[10] ? lc3b_isa_pkg::op_ldr : lc3b_isa_pkg::op_str;
			default: ins.alu.opcode = lc3b_isa_pkg::op_jmp;
		endcase
		return ins;
	endfunction

	// Four-phase handshake, entered 1 ns after a rising edge
	task automatic send_fetch(input tomasulo_pkg::fetch_t f);
		int waited;
		fetch = f;
		fetch_req = 1'b1;
		waited = 0;
		while (!fetch_ack)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > ACK_LIMIT)
				abort_run("Timeout waiting for fetch_ack to rise");
		end
		fetch_req = 1'b0;
		waited = 0;
		while (fetch_ack)
		begin
			@(posedge clk);
			#1;
			waited++;
			if (waited > ACK_LIMIT)
				abort_run("Timeout waiting for fetch_ack to fall");
		end
	endtask

	task automatic issue_word(input lc3b_isa_pkg::lc3b_instr ins);
		tomasulo_pkg::fetch_t f;
		tomasulo_pkg::retire_t expected;
		logic [15:0] r;
		r = next_random();
		pc = pc + 16'd2;
		f.instr = ins;
		f.pc = pc;
		f.predict_taken = r[0];
		expected = model_step(f);
		// Entries are handed out in a circle starting at zero
		expected.entry = tomasulo_pkg::rob_addr_t'(alloc_count % `ROB_DEPTH);
		alloc_count++;
		pending_retires.push_back(expected);
		send_fetch(f);
	endtask

	// Retirements compared at the falling edge where they are stable
	always @(negedge clk)
	begin
		if (rst_n && retire.valid)
		begin
			if (pending_retires.size() == 0)
				abort_run($sformatf("Retirement at %0t with nothing left to retire", $time));
			else
			begin
				want = pending_retires.pop_front();
				assert (retire.opcode == want.opcode)
				else abort_run($sformatf("Error at %0t: retire.opcode is %h, expected %h",
					$time, retire.opcode, want.opcode));
				assert (retire.has_dest == want.has_dest)
				else abort_run($sformatf("Error at %0t: retire.has_dest is %b, expected %b",
					$time, retire.has_dest, want.has_dest));
				assert (!want.has_dest || retire.dest == want.dest)
				else abort_run($sformatf("Error at %0t: retire.dest is %0d, expected %0d",
					$time, retire.dest, want.dest));
				assert (!(want.has_dest || want.opcode == lc3b_isa_pkg::op_br) ||
					retire.value == want.value)
				else abort_run($sformatf("Error at %0t: retire.value is %h, expected %h",
					$time, retire.value, want.value));
				assert (retire.entry == want.entry)
				else abort_run($sformatf("Error at %0t: retire.entry is %0d, expected %0d",
					$time, retire.entry, want.entry));
			end
		end
	end

	initial
	begin
		int waited;
		rst_n = 1'b0;
		fetch_req = 1'b0;
		fetch = '0;
		pc = 16'h3000;
		alloc_count = 0;
		for (int i = 0; i < 8; i++)
			ref_regs[i] = '0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;
		for (int i = 0; i < 6; i++)
			issue_word(16'h1261);   // ADD r1, r1, #1 chain
		for (int i = 0; i < RANDOM_COUNT; i++)
			issue_word(random_instr());
		waited = 0;
		while (pending_retires.size() != 0 && waited < DRAIN_LIMIT)
		begin
			@(posedge clk);
			waited++;
		end
		if (pending_retires.size() == 0)
		begin
			$display("Everything OK");
			$finish;
		end
		else
			abort_run($sformatf("%0d instructions never retired", pending_retires.size()));
	end

endmodule

/* tomasulo_core.f */
+incdir+source
source/lc3b_isa_pkg.sv
source/tomasulo_pkg.sv
source/issue_control.sv
source/reg_status.sv
source/alu_stations.sv
source/reorder_buffer.sv
source/tomasulo_core.sv
tests/tomasulo_core_sva.sv
tests/tomasulo_core_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal \
	--top-module tomasulo_core_tb -f tomasulo_core.f -o tomasulo_core_sim &&
./obj_dir/tomasulo_core_sim || exit 1
